/* fp16_mul.f */
hdl/fp16_pkg.sv
hdl/fp16_unpack.sv
hdl/mul_wallacetree.sv
hdl/fp16_round.sv
hdl/fp16_mul_top.sv
verif/fp16_mul_tb.sv

/* hdl/fp16_mul_top.sv */
/*
 * FP16 multiplier top level, three pipeline stages with one shared enable
 */

`timescale 1ns/1ps

module fp16_mul_top import fp16_pkg::*; (
    input  logic  clk,
    input  logic  nRST,
    input  logic  in_valid,
    output logic  in_ready,
    input  fp16_t in_a,
    input  fp16_t in_b,
    output logic  out_valid,
    input  logic  out_ready,
    output fp16_t out_data
);

    logic        advance;
    logic        s1_valid;
    mul_side_t   s1_side;
    logic [10:0] s1_man_a;
    logic [10:0] s1_man_b;
    logic [12:0] result;
    logic        overflow;
    logic        round_loss;
    logic        value_ready;

    fp16_unpack u_unpack (
        .clk(clk), .nRST(nRST), .in_valid(in_valid), .advance(advance),
        .in_a(in_a), .in_b(in_b), .in_ready(in_ready), .s1_valid(s1_valid),
        .s1_side(s1_side), .s1_man_a(s1_man_a), .s1_man_b(s1_man_b)
    );

    mul_wallacetree u_tree (
        .clk(clk), .nRST(nRST), .a(s1_man_a), .b(s1_man_b),
        .in_valid(s1_valid), .active(advance), .result(result),
        .overflow(overflow), .round_loss(round_loss), .value_ready(value_ready)
    );

    fp16_round u_round (
        .clk(clk), .nRST(nRST), .s1_side(s1_side), .result(result),
        .overflow(overflow), .round_loss(round_loss), .value_ready(value_ready),
        .out_ready(out_ready), .advance(advance), .out_valid(out_valid),
        .out_data(out_data)
    );

endmodule

/* hdl/fp16_pkg.sv */
/*
 * FP16 multiplier shared definitions: the half precision word, operand
 * classes, the sideband that travels with the mantissa, and the adder cells
 */

package fp16_pkg;

    // one IEEE half precision word
    typedef struct packed {
        logic       sign;
        logic [4:0] exp;
        logic [9:0] frac;
    } fp16_t;

    // subnormals are classified as zero
    typedef enum logic [1:0] {
        FP_ZERO   = 2'd0,
        FP_NORMAL = 2'd1,
        FP_INF    = 2'd2,
        FP_NAN    = 2'd3
    } fp_class_e;

    // sign, result class and exponent sum, kept beside the significands
    typedef struct packed {
        logic              sign;
        fp_class_e         cls;
        logic signed [6:0] exp;
    } mul_side_t;

    // carry sits above sum so {carry, sum} reads as a 2-bit count
    typedef struct packed {
        logic carry;
        logic sum;
    } sum_carry_t;

    localparam int    EXP_BIAS = 15;
    localparam int    EXP_MAX  = 31;
    localparam fp16_t QNAN     = 16'h7E00;

    function automatic sum_carry_t ha_cell(input logic x, input logic y);
        sum_carry_t r;
        r.sum   = x ^ y;
        r.carry = x & y;
        return r;
    endfunction

    function automatic sum_carry_t fa_cell(input logic x, input logic y, input logic z);
        sum_carry_t r;
        r.sum   = x ^ y ^ z;
        r.carry = (x & y) | (x & z) | (y & z);
        return r;
    endfunction

endpackage

/* hdl/fp16_round.sv */
/*
 * FP16 multiplier round stage. Normalizes the product, rounds to nearest
 * even, applies range and special cases and owns the output handshake
 */

`timescale 1ns/1ps

module fp16_round import fp16_pkg::*; (
    input  logic        clk,
    input  logic        nRST,
    input  mul_side_t   s1_side,
    input  logic [12:0] result,
    input  logic        overflow,
    input  logic        round_loss,
    input  logic        value_ready,
    input  logic        out_ready,
    output logic        advance,
    output logic        out_valid,
    output fp16_t       out_data
);

    mul_side_t         side_q;
    logic [9:0]        frac;
    logic              guard;
    logic              sticky;
    logic              round_up;
    logic [10:0]       frac_rnd;
    logic signed [6:0] exp_fin;
    fp16_t             res;

    // stall everything only when a result is waiting and not taken
    assign advance = !out_valid || out_ready;

    // sideband lines up with the tree's carry-save register
    always_ff @(posedge clk)
    begin
        if (advance)
            side_q <= s1_side;
    end

    always_comb
    begin
        if (overflow)
        begin
            frac   = result[12:3];
            guard  = result[2];
            sticky = |result[1:0] | round_loss;
        end
        else
        begin
            frac   = result[11:2];
            guard  = result[1];
            sticky = result[0] | round_loss;
        end
        // ties go to the even fraction
        round_up = guard & (sticky | frac[0]);
        frac_rnd = {1'b0, frac} + {10'd0, round_up};
        exp_fin  = side_q.exp + {6'd0, overflow} + {6'd0, frac_rnd[10]};

        res.sign = side_q.sign;
        res.exp  = exp_fin[4:0];
        res.frac = frac_rnd[9:0];
        if (side_q.cls == FP_NAN)
            res = QNAN;
        else if (side_q.cls == FP_INF || (side_q.cls == FP_NORMAL && exp_fin >= EXP_MAX))
        begin
            res.exp  = 5'(EXP_MAX);
            res.frac = 10'd0;
        end
        else if (side_q.cls == FP_ZERO || exp_fin <= 0)
        begin
            // underflow flushes to zero, sign kept
            res.exp  = 5'd0;
            res.frac = 10'd0;
        end
    end

    always_ff @(posedge clk, negedge nRST)
    begin
        if (!nRST)
            out_valid <= 1'b0;
        else if (advance)
            out_valid <= value_ready;
    end

    always_ff @(posedge clk)
    begin
        if (advance)
            out_data <= res;
    end

    assert property (@(posedge clk) disable iff (!nRST)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* hdl/fp16_unpack.sv */
/*
 * FP16 multiplier unpack stage. Takes operand pairs on the input handshake,
 * classifies them, forms sign and exponent sum and restores hidden bits
 */

`timescale 1ns/1ps

module fp16_unpack import fp16_pkg::*; (
    input  logic        clk,
    input  logic        nRST,
    input  logic        in_valid,
    input  logic        advance,
    input  fp16_t       in_a,
    input  fp16_t       in_b,
    output logic        in_ready,
    output logic        s1_valid,
    output mul_side_t   s1_side,
    output logic [10:0] s1_man_a,
    output logic [10:0] s1_man_b
);

    fp_class_e cls_a;
    fp_class_e cls_b;
    mul_side_t side;

    // exponent zero covers subnormals too, they get flushed
    function automatic fp_class_e classify(input fp16_t x);
        if (x.exp == 5'd0)
            return FP_ZERO;
        else if (x.exp == 5'(EXP_MAX))
            return (x.frac != 10'd0) ? FP_NAN : FP_INF;
        else
            return FP_NORMAL;
    endfunction

    // whole pipeline moves together, so a pair is taken whenever it advances
    assign in_ready = advance;

    always_comb
    begin
        cls_a     = classify(in_a);
        cls_b     = classify(in_b);
        side.sign = in_a.sign ^ in_b.sign;
        side.exp  = 7'(in_a.exp) + 7'(in_b.exp) - 7'(EXP_BIAS);
        // inf times zero is invalid as well
        if (cls_a == FP_NAN || cls_b == FP_NAN ||
            (cls_a == FP_INF && cls_b == FP_ZERO) ||
            (cls_a == FP_ZERO && cls_b == FP_INF))
            side.cls = FP_NAN;
        else if (cls_a == FP_INF || cls_b == FP_INF)
            side.cls = FP_INF;
        else if (cls_a == FP_ZERO || cls_b == FP_ZERO)
            side.cls = FP_ZERO;
        else
            side.cls = FP_NORMAL;
    end

    always_ff @(posedge clk, negedge nRST)
    begin
        if (!nRST)
            s1_valid <= 1'b0;
        else if (advance)
            s1_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            s1_side  <= side;
            s1_man_a <= {1'b1, in_a.frac};
            s1_man_b <= {1'b1, in_b.frac};
        end
    end

    assert property (@(posedge clk) disable iff (!nRST)
        s1_valid |-> !$isunknown(s1_side.cls));

endmodule

/* hdl/mul_wallacetree.sv */
/*
 * 11x11 Wallace tree significand multiplier. Five compression stages end in
 * a sum row and a carry row, which are registered and then added
 */

`timescale 1ns/1ps

module mul_wallacetree import fp16_pkg::*; (
    input  logic        clk,
    input  logic        nRST,
    input  logic [10:0] a,
    input  logic [10:0] b,
    input  logic        in_valid,
    input  logic        active,
    output logic [12:0] result,
    output logic        overflow,
    output logic        round_loss,
    output logic        value_ready
);

    // stage 1: three groups of three partial product rows, group i at weight 3i
    logic [2:0][12:0] st1_sum;
    logic [2:0][10:0] st1_cry;
    // stage 2: group 0 with group 1 sums, and group 1 carries with group 2
    logic [15:0] st2a_sum;
    logic [10:0] st2a_cry;
    logic [13:0] st2b_sum;
    logic [12:0] st2b_cry;
    // stage 3: second half also takes rows a[9] and a[10]
    logic [18:0] st3a_sum;
    logic [12:0] st3a_cry;
    logic [13:0] st3b_sum;
    logic [10:0] st3b_cry;
    logic [20:0] st4_sum;
    logic [14:0] st4_cry;
    logic [20:0] st5_sum;
    logic [15:0] st5_cry;
    // carry row starts at weight 6
    logic [20:0] sum_q;
    logic [15:0] cry_q;
    logic [21:0] product;

    always_comb
    begin
        for (int i = 0; i < 3; i++)
        begin
            st1_sum[i][0] = a[3*i] & b[0];
            {st1_cry[i][0], st1_sum[i][1]} = ha_cell(a[3*i] & b[1], a[3*i+1] & b[0]);
            for (int j = 2; j <= 10; j++)
                {st1_cry[i][j-1], st1_sum[i][j]} =
                    fa_cell(a[3*i] & b[j], a[3*i+1] & b[j-1], a[3*i+2] & b[j-2]);
            {st1_cry[i][10], st1_sum[i][11]} = ha_cell(a[3*i+1] & b[10], a[3*i+2] & b[9]);
            st1_sum[i][12] = a[3*i+2] & b[10];
        end
    end

    always_comb
    begin
        st2a_sum[1:0] = st1_sum[0][1:0];
        {st2a_cry[0], st2a_sum[2]} = ha_cell(st1_sum[0][2], st1_cry[0][0]);
        for (int k = 3; k <= 12; k++)
            {st2a_cry[k-2], st2a_sum[k]} =
                fa_cell(st1_sum[0][k], st1_cry[0][k-2], st1_sum[1][k-3]);
        st2a_sum[15:13] = st1_sum[1][12:10];
    end

    // bit m of the second half sits at weight m+5
    always_comb
    begin
        st2b_sum[0] = st1_cry[1][0];
        for (int m = 1; m <= 2; m++)
            {st2b_cry[m-1], st2b_sum[m]} = ha_cell(st1_cry[1][m], st1_sum[2][m-1]);
        for (int m = 3; m <= 10; m++)
            {st2b_cry[m-1], st2b_sum[m]} =
                fa_cell(st1_cry[1][m], st1_sum[2][m-1], st1_cry[2][m-3]);
        for (int m = 11; m <= 13; m++)
            {st2b_cry[m-1], st2b_sum[m]} = ha_cell(st1_sum[2][m-1], st1_cry[2][m-3]);
    end

    always_comb
    begin
        st3a_sum[2:0] = st2a_sum[2:0];
        for (int n = 3; n <= 4; n++)
            {st3a_cry[n-3], st3a_sum[n]} = ha_cell(st2a_sum[n], st2a_cry[n-3]);
        for (int n = 5; n <= 13; n++)
            {st3a_cry[n-3], st3a_sum[n]} =
                fa_cell(st2a_sum[n], st2a_cry[n-3], st2b_sum[n-5]);
        for (int n = 14; n <= 15; n++)
            {st3a_cry[n-3], st3a_sum[n]} = ha_cell(st2a_sum[n], st2b_sum[n-5]);
        st3a_sum[18:16] = st2b_sum[13:11];
    end

    // bit o here sits at weight o+7
    always_comb
    begin
        st3b_sum[1:0] = st2b_cry[1:0];
        {st3b_cry[0], st3b_sum[2]} = ha_cell(st2b_cry[2], a[9] & b[0]);
        for (int o = 3; o <= 12; o++)
            {st3b_cry[o-2], st3b_sum[o]} =
                fa_cell(st2b_cry[o], a[9] & b[o-2], a[10] & b[o-3]);
        st3b_sum[13] = a[10] & b[10];
    end

    always_comb
    begin
        st4_sum[3:0] = st3a_sum[3:0];
        for (int p = 4; p <= 6; p++)
            {st4_cry[p-4], st4_sum[p]} = ha_cell(st3a_sum[p], st3a_cry[p-4]);
        for (int p = 7; p <= 16; p++)
            {st4_cry[p-4], st4_sum[p]} =
                fa_cell(st3a_sum[p], st3a_cry[p-4], st3b_sum[p-7]);
        for (int p = 17; p <= 18; p++)
            {st4_cry[p-4], st4_sum[p]} = ha_cell(st3a_sum[p], st3b_sum[p-7]);
        st4_sum[20:19] = st3b_sum[13:12];
    end

    // last stage folds in the stage 3 carries that were left over
    always_comb
    begin
        st5_sum[4:0] = st4_sum[4:0];
        for (int q = 5; q <= 9; q++)
            {st5_cry[q-5], st5_sum[q]} = ha_cell(st4_sum[q], st4_cry[q-5]);
        for (int q = 10; q <= 19; q++)
            {st5_cry[q-5], st5_sum[q]} =
                fa_cell(st4_sum[q], st4_cry[q-5], st3b_cry[q-10]);
        {st5_cry[15], st5_sum[20]} = ha_cell(st4_sum[20], st3b_cry[10]);
    end

    always_ff @(posedge clk, negedge nRST)
    begin
        if (!nRST)
            value_ready <= 1'b0;
        else if (active)
            value_ready <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (active)
        begin
            sum_q <= st5_sum;
            cry_q <= st5_cry;
        end
    end

    assign product    = {1'b0, sum_q} + {cry_q, 6'b0};
    assign overflow   = product[21];
    assign result     = product[20:8];
    assign round_loss = |product[7:0];

    // two normalized significands always give at least 1.0
    assert property (@(posedge clk) disable iff (!nRST)
        active && in_valid && a[10] && b[10] |=> value_ready && (product >= 22'h100000));

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the FP16 multiplier testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module fp16_mul_tb -f fp16_mul.f -o Vfp16_mul_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vfp16_mul_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* verif/fp16_mul_tb.sv */
/*
 * FP16 multiplier testbench. Runs the vector file once as a back to back
 * burst and once with random gaps and output stalls, checking every result
 */

`timescale 1ns/1ps

module fp16_mul_tb import fp16_pkg::*; ();

    localparam int    CLK_PERIOD = 100;
    localparam string TEST_FILE  = "verif/fp16_mul_tests.txt";

    logic  clk;
    logic  nRST;
    logic  in_valid;
    logic  in_ready;
    fp16_t in_a;
    fp16_t in_b;
    logic  out_valid;
    logic  out_ready;
    fp16_t out_data;

    logic [15:0] vec_a[$];
    logic [15:0] vec_b[$];
    logic [15:0] vec_exp[$];
    int          n_tests = 0;
    logic        loaded;

    // scoreboard, one entry per accepted pair
    logic [15:0] exp_q[$];
    int          stamp_q[$];
    logic        burst_q[$];
    logic [15:0] cur_exp;
    logic        cur_burst;
    logic        random_ready;
    logic        hold_check = 1'b0;
    fp16_t       held_data;
    int          cycle_count = 0;
    int          received = 0;
    int          errors = 0;

    fp16_mul_top UUT (
        .clk(clk), .nRST(nRST), .in_valid(in_valid), .in_ready(in_ready),
        .in_a(in_a), .in_b(in_b), .out_valid(out_valid), .out_ready(out_ready),
        .out_data(out_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_tests();
        int          fd;
        string       line;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] e;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0)
        begin
            $display("cannot open test file %s", TEST_FILE);
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            // lines starting with # are comments
            if (line.len() > 0 && line[0] != "#")
            begin
                if ($sscanf(line, "%h %h %h", a, b, e) == 3)
                begin
                    vec_a.push_back(a);
                    vec_b.push_back(b);
                    vec_exp.push_back(e);
                end
            end
        end
        $fclose(fd);
        n_tests = vec_a.size();
    endtask

    // holds the pair until the edge that takes it
    task automatic drive_pair(input int idx, input logic burst);
        in_valid  <= 1'b1;
        in_a      <= vec_a[idx];
        in_b      <= vec_b[idx];
        cur_exp   <= vec_exp[idx];
        cur_burst <= burst;
        @(posedge clk);
        // the pipeline never stalls in the burst, so the first edge must take the pair
        if (burst)
            assert (in_ready)
            else
            begin
                errors++;
                $display("FAILED at %0t: in_ready low while out_ready is held high", $time);
            end
        while (!in_ready)
            @(posedge clk);
    endtask

    task automatic idle_cycles(input int n);
        in_valid <= 1'b0;
        repeat (n)
            @(posedge clk);
    endtask

    task automatic wait_drained(input int total);
        in_valid <= 1'b0;
        while (received < total)
            @(posedge clk);
    endtask

    task automatic check_result();
        logic [15:0] want;
        int          stamp;
        logic        burst;
        assert (exp_q.size() > 0)
        else
        begin
            errors++;
            $display("result %h arrived with no pair outstanding", out_data);
        end
        if (exp_q.size() > 0)
        begin
            want  = exp_q.pop_front();
            stamp = stamp_q.pop_front();
            burst = burst_q.pop_front();
            received++;
            assert (out_data == want)
            else
            begin
                errors++;
                $display("FAILED at %0t: expected %h, received %h", $time, want, out_data);
            end
            // out_valid rises two edges after acceptance, the transfer is on the third
            if (burst)
                assert (cycle_count == stamp + 3)
                else
                begin
                    errors++;
                    $display("FAILED at %0t: latency %0d edges, expected 3",
                             $time, cycle_count - stamp);
                end
        end
    endtask

    always @(posedge clk)
    begin
        if (random_ready)
            out_ready <= ($urandom % 4) != 0;
        else
            out_ready <= 1'b1;
    end

    // handshakes are sampled with the values the edge itself sees
    always @(posedge clk)
    begin
        if (nRST)
        begin
            if (in_valid && in_ready)
            begin
                exp_q.push_back(cur_exp);
                stamp_q.push_back(cycle_count);
                burst_q.push_back(cur_burst);
            end
            if (hold_check)
                assert (out_data == held_data)
                else
                begin
                    errors++;
                    $display("FAILED at %0t: out_data changed from %h to %h during a stall",
                             $time, held_data, out_data);
                end
            if (out_valid && out_ready)
                check_result();
            hold_check = out_valid && !out_ready;
            held_data  = out_data;
        end
        cycle_count++;
    end

    initial
    begin
        wait (loaded && n_tests > 0);
        #(20 * n_tests * CLK_PERIOD);
        $display("timeout, only %0d of %0d results arrived", received, 2 * n_tests);
        $display("Testbench failed");
        $finish;
    end

    initial
    begin
        nRST         = 1'b0;
        in_valid     = 1'b0;
        in_a         = '0;
        in_b         = '0;
        out_ready    = 1'b1;
        cur_exp      = '0;
        cur_burst    = 1'b0;
        random_ready = 1'b0;
        loaded       = 1'b0;
        void'($urandom(1));
        load_tests();
        loaded = 1'b1;
        repeat (2)
            @(posedge clk);
        nRST <= 1'b1;
        @(posedge clk);
        if (n_tests > 0)
        begin
            // burst with the output never stalled
            for (int i = 0; i < n_tests; i++)
                drive_pair(i, 1'b1);
            wait_drained(n_tests);
            random_ready <= 1'b1;
            for (int i = 0; i < n_tests; i++)
            begin
                idle_cycles($urandom % 3);
                drive_pair(i, 1'b0);
            end
            wait_drained(2 * n_tests);
        end
        else
        begin
            errors++;
            $display("no test vectors were read from %s", TEST_FILE);
        end
        $display("%0d results checked, %0d errors", received, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* verif/fp16_mul_tests.txt */
# operand_a operand_b expected, FP16 words in hex
# exact products, rounding, range, then special operands
3E00 4000 4200
C200 3800 BE00
4200 4200 4880
4000 C000 C400
3C03 3CC8 3CCC
3C01 3C01 3C02
3C02 3D00 3D02
3C01 3E00 3E02
3DA8 3DA8 4000
3DFF 3DFF 407F
7800 7800 7C00
F800 7800 FC00
7BFF 3C01 7C00
0400 0400 0000
8400 0400 8000
0400 3800 0000
0400 3C00 0400
0001 3C00 0000
8001 3C00 8000
7E00 3C00 7E00
FE00 4000 7E00
7C00 0000 7E00
7C00 C000 FC00
FC00 BC00 7C00
0000 C200 8000
7C00 0001 7E00
